// ==== design/vend_pkg.sv ====
package vend_pkg;

    //////////////////////////////////////////////////
    // sizes and limits
    //////////////////////////////////////////////////
    localparam int NUM_ITEMS = 4;
    localparam int ITEM_W    = 2;
    localparam int STOCK_W   = 4;
    localparam int CREDIT_W  = 8;
    localparam int KEY_W     = 12;
    localparam int MSG_HOLD  = 16;
    localparam int HOLD_W    = $clog2(MSG_HOLD);

    // key bus bit positions
    localparam int KEY_COIN10  = 0;
    localparam int KEY_COIN5   = 1;
    localparam int KEY_COIN1   = 2;
    localparam int KEY_REFUND  = 3;
    localparam int KEY_DOWN    = 4;
    localparam int KEY_RESTOCK = 5;
    localparam int KEY_SELECT  = 7;
    localparam int KEY_BUY     = 9;
    localparam int KEY_UP      = 10;
    localparam int KEY_ADMIN   = 11;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////
    typedef logic [STOCK_W-1:0]   stock_t;
    typedef logic [CREDIT_W-1:0]  credit_t;
    typedef logic [ITEM_W-1:0]    item_t;
    typedef logic [NUM_ITEMS-1:0] item_mask_t;
    typedef stock_t [NUM_ITEMS-1:0] stock_arr_t;

    typedef enum logic [2:0] {
        MSG_NONE,
        MSG_SOLD_OUT,
        MSG_SHORT,
        MSG_THANKS,
        MSG_ADMIN
    } msg_t;

    // item is one-hot over the products
    typedef struct packed {
        logic       sell;
        logic       restock;
        item_mask_t item;
    } ledger_cmd_t;

    typedef struct packed {
        logic    add;
        credit_t amount;
        logic    charge;
        credit_t price;
        logic    refund;
    } credit_cmd_t;

    typedef struct packed {
        item_t cursor;
        logic  sel_valid;
        item_t sel_item;
        logic  admin;
        msg_t  msg;
        item_t msg_item;
    } panel_t;

    localparam stock_t  STOCK_MAX  = 4'd9;
    localparam credit_t CREDIT_MAX = 8'd99;

    localparam stock_t STOCK_INIT0 = 4'd9;
    localparam stock_t STOCK_INIT1 = 4'd1;
    localparam stock_t STOCK_INIT2 = 4'd0;
    localparam stock_t STOCK_INIT3 = 4'd4;
    localparam stock_arr_t STOCK_INIT = {STOCK_INIT3, STOCK_INIT2, STOCK_INIT1, STOCK_INIT0};

    //////////////////////////////////////////////////
    // lookups
    //////////////////////////////////////////////////
    function automatic credit_t price_of(input item_t item);
        case (item)
            2'd0:    return 8'd10;
            2'd1:    return 8'd12;
            2'd2:    return 8'd15;
            default: return 8'd18;
        endcase
    endfunction

    // coins ordered {coin1, coin5, coin10}, anything but one hot is worth nothing
    function automatic credit_t coin_value(input logic [2:0] coins);
        case (coins)
            3'b100:  return 8'd1;
            3'b010:  return 8'd5;
            3'b001:  return 8'd10;
            default: return 8'd0;
        endcase
    endfunction

    function automatic item_mask_t item_onehot(input item_t item);
        return item_mask_t'(1) << item;
    endfunction

    // shared by the ledger and the forwarding path in sale control
    function automatic stock_t next_stock(input stock_t cur, input logic sell,
                                          input logic restock);
        if (sell && cur != '0)
            return cur - 4'd1;
        if (restock && cur != STOCK_MAX)
            return cur + 4'd1;
        return cur;
    endfunction

    function automatic credit_t next_credit(input credit_t cur, input credit_cmd_t cmd);
        if (cmd.add)
            return cur + cmd.amount;
        if (cmd.charge)
            return cur - cmd.price;
        return cur;
    endfunction

endpackage

// ==== design/vend_sale_control.sv ====
module vend_sale_control (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [vend_pkg::KEY_W-1:0]   keys,
    input  vend_pkg::stock_arr_t         stock,
    input  vend_pkg::credit_t            credit,
    input  logic                         busy,
    output vend_pkg::ledger_cmd_t        ledger_cmd,
    output vend_pkg::credit_cmd_t        credit_cmd,
    output vend_pkg::panel_t             panel
);

    logic [vend_pkg::HOLD_W-1:0] hold_cnt;

    // values seen one cycle ahead of the ledger and credit registers
    vend_pkg::stock_arr_t eff_stock;
    vend_pkg::credit_t    eff_credit;
    logic                 eff_busy;

    logic [2:0]        coins;
    vend_pkg::credit_t coin_amt;
    logic              coin_ok;
    vend_pkg::stock_t  cur_stock;
    vend_pkg::stock_t  sel_stock;
    vend_pkg::credit_t sel_price;

    logic key_up;
    logic key_down;
    logic key_sel;
    logic key_coin;
    logic key_buy;
    logic key_refund;
    logic key_restock;
    logic key_admin;

    //////////////////////////////////////////////////
    // forwarding of the pending commands
    //////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < vend_pkg::NUM_ITEMS; i++) begin
            eff_stock[i] = vend_pkg::next_stock(stock[i],
                                                ledger_cmd.sell & ledger_cmd.item[i],
                                                ledger_cmd.restock & ledger_cmd.item[i]);
        end
        eff_credit = vend_pkg::next_credit(credit, credit_cmd);
        // refund already issued but payout not yet started
        eff_busy   = busy | (credit_cmd.refund & (credit != '0));
    end

    //////////////////////////////////////////////////
    // key decode
    //////////////////////////////////////////////////
    always_comb begin
        coins       = keys[vend_pkg::KEY_COIN1:vend_pkg::KEY_COIN10];
        coin_amt    = vend_pkg::coin_value(coins);
        coin_ok     = $onehot(coins) && (eff_credit + coin_amt <= vend_pkg::CREDIT_MAX);
        cur_stock   = eff_stock[panel.cursor];
        sel_stock   = eff_stock[panel.sel_item];
        sel_price   = vend_pkg::price_of(panel.sel_item);

        key_up      = keys[vend_pkg::KEY_UP];
        key_down    = keys[vend_pkg::KEY_DOWN];
        key_sel     = keys[vend_pkg::KEY_SELECT];
        // money keys are dead while the hopper pays out
        key_coin    = (|coins) & ~eff_busy;
        key_buy     = keys[vend_pkg::KEY_BUY] & ~eff_busy;
        key_refund  = keys[vend_pkg::KEY_REFUND] & ~eff_busy;
        key_restock = keys[vend_pkg::KEY_RESTOCK];
        key_admin   = keys[vend_pkg::KEY_ADMIN];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            panel      <= '0;
            hold_cnt   <= '0;
            ledger_cmd <= '0;
            credit_cmd <= '0;
        end else begin
            // commands are single cycle pulses
            ledger_cmd <= '0;
            credit_cmd <= '0;

            // message hold timer, a new message below overrides it
            if (panel.msg != vend_pkg::MSG_NONE) begin
                if (hold_cnt == '0) begin
                    panel.msg      <= vend_pkg::MSG_NONE;
                    panel.msg_item <= '0;
                end else begin
                    hold_cnt <= hold_cnt - 1'b1;
                end
            end

            if (key_up || key_down) begin
                if (key_up) begin
                    if (panel.cursor != '0)
                        panel.cursor <= panel.cursor - 1'b1;
                end else if (panel.cursor != vend_pkg::ITEM_W'(vend_pkg::NUM_ITEMS - 1)) begin
                    panel.cursor <= panel.cursor + 1'b1;
                end
            end else if (key_sel) begin
                if (panel.sel_valid && panel.sel_item == panel.cursor) begin
                    panel.sel_valid <= 1'b0;
                end else if (cur_stock != '0) begin
                    panel.sel_valid <= 1'b1;
                    panel.sel_item  <= panel.cursor;
                end
            end else if (key_coin) begin
                // multi-bit coin pulses use up the cycle but add nothing
                if (coin_ok) begin
                    credit_cmd.add    <= 1'b1;
                    credit_cmd.amount <= coin_amt;
                end
            end else if (key_buy) begin
                if (panel.sel_valid) begin
                    panel.msg_item  <= panel.sel_item;
                    hold_cnt        <= vend_pkg::HOLD_W'(vend_pkg::MSG_HOLD - 1);
                    panel.sel_valid <= 1'b0;
                    if (sel_stock != '0 && eff_credit >= sel_price) begin
                        ledger_cmd.sell   <= 1'b1;
                        ledger_cmd.item   <= vend_pkg::item_onehot(panel.sel_item);
                        credit_cmd.charge <= 1'b1;
                        credit_cmd.price  <= sel_price;
                        panel.msg         <= vend_pkg::MSG_THANKS;
                    end else if (sel_stock == '0) begin
                        panel.msg <= vend_pkg::MSG_SOLD_OUT;
                    end else begin
                        panel.msg <= vend_pkg::MSG_SHORT;
                    end
                end
            end else if (key_refund) begin
                credit_cmd.refund <= 1'b1;
            end else if (key_restock) begin
                // stock cap is the ledger's job
                if (panel.admin) begin
                    ledger_cmd.restock <= 1'b1;
                    ledger_cmd.item    <= vend_pkg::item_onehot(panel.cursor);
                end
            end else if (key_admin) begin
                panel.admin <= ~panel.admin;
                if (!panel.admin) begin
                    panel.msg      <= vend_pkg::MSG_ADMIN;
                    panel.msg_item <= panel.cursor;
                    hold_cnt       <= vend_pkg::HOLD_W'(vend_pkg::MSG_HOLD - 1);
                end
            end
        end
    end

endmodule

// ==== design/vend_stock_ledger.sv ====
module vend_stock_ledger (
    input  logic                  clk,
    input  logic                  rst,
    input  vend_pkg::ledger_cmd_t ledger_cmd,
    output vend_pkg::stock_arr_t  stock
);

    //////////////////////////////////////////////////
    // per-product counters
    //////////////////////////////////////////////////

    // only the addressed counter moves, the others hold
    always_ff @(posedge clk) begin
        if (!rst) begin
            stock <= vend_pkg::STOCK_INIT;
        end else begin
            for (int i = 0; i < vend_pkg::NUM_ITEMS; i++) begin
                if (ledger_cmd.item[i]) begin
                    // restock saturates at STOCK_MAX inside next_stock
                    stock[i] <= vend_pkg::next_stock(stock[i], ledger_cmd.sell,
                                                     ledger_cmd.restock);
                end
            end
        end
    end

endmodule

// ==== design/vend_credit.sv ====
module vend_credit (
    input  logic                  clk,
    input  logic                  rst,
    input  vend_pkg::credit_cmd_t credit_cmd,
    output vend_pkg::credit_t     credit,
    output logic                  busy,
    output logic                  coin_req,
    input  logic                  coin_ack
);

    // payout FSM for the hopper handshake
    typedef enum logic [1:0] {
        PAY_IDLE,
        PAY_REQ,
        PAY_WAIT
    } pay_state_t;

    pay_state_t state;

    assign busy = (state != PAY_IDLE);

    //////////////////////////////////////////////////
    // credit register and payout
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            credit   <= '0;
            coin_req <= 1'b0;
            state    <= PAY_IDLE;
        end else begin
            case (state)
                PAY_IDLE: begin
                    credit <= vend_pkg::next_credit(credit, credit_cmd);
                    // refund of an empty credit does nothing
                    if (credit_cmd.refund && credit != '0) begin
                        if (!coin_ack) begin
                            coin_req <= 1'b1;
                            state    <= PAY_REQ;
                        end else begin
                            state <= PAY_WAIT;
                        end
                    end
                end

                PAY_REQ: begin
                    // one unit leaves per acknowledged request
                    if (coin_ack) begin
                        coin_req <= 1'b0;
                        credit   <= credit - 1'b1;
                        if (credit == vend_pkg::credit_t'(1))
                            state <= PAY_IDLE;
                        else
                            state <= PAY_WAIT;
                    end
                end

                PAY_WAIT: begin
                    // hopper must drop ack before the next request
                    if (!coin_ack) begin
                        coin_req <= 1'b1;
                        state    <= PAY_REQ;
                    end
                end

                default: begin
                    coin_req <= 1'b0;
                    state    <= PAY_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/vend_top.sv ====
module vend_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [vend_pkg::KEY_W-1:0] keys,
    input  logic                       coin_ack,
    output vend_pkg::panel_t           panel,
    output vend_pkg::credit_t          credit,
    output vend_pkg::stock_t           stock_shown,
    output logic                       coin_req
);

    vend_pkg::stock_arr_t  stock;
    vend_pkg::ledger_cmd_t ledger_cmd;
    vend_pkg::credit_cmd_t credit_cmd;
    logic                  busy;

    //////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////
    vend_sale_control sale0 (
        .clk        (clk),
        .rst        (rst),
        .keys       (keys),
        .stock      (stock),
        .credit     (credit),
        .busy       (busy),
        .ledger_cmd (ledger_cmd),
        .credit_cmd (credit_cmd),
        .panel      (panel)
    );

    vend_stock_ledger ledger0 (
        .clk        (clk),
        .rst        (rst),
        .ledger_cmd (ledger_cmd),
        .stock      (stock)
    );

    vend_credit credit0 (
        .clk        (clk),
        .rst        (rst),
        .credit_cmd (credit_cmd),
        .credit     (credit),
        .busy       (busy),
        .coin_req   (coin_req),
        .coin_ack   (coin_ack)
    );

    // count of the product under the cursor
    assign stock_shown = stock[panel.cursor];

endmodule

// ==== dv/vend_credit_props.sv ====
module vend_credit_props (
    input logic              clk,
    input logic              rst,
    input vend_pkg::credit_t credit,
    input logic              busy,
    input logic              coin_req,
    input logic              coin_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    // request may only rise after the hopper saw ack low
    req_rise_ack_low: assert property (@(posedge clk) disable iff (!rst)
        $rose(coin_req) |-> !$past(coin_ack))
        else begin
            $error("coin_req rose while coin_ack was high");
            fail_cnt++;
        end

    req_held: assert property (@(posedge clk) disable iff (!rst)
        coin_req && !coin_ack |=> coin_req)
        else begin
            $error("coin_req dropped before coin_ack");
            fail_cnt++;
        end

    credit_cap: assert property (@(posedge clk) disable iff (!rst)
        credit <= vend_pkg::CREDIT_MAX)
        else begin
            $error("credit above the cap");
            fail_cnt++;
        end

    idle_when_empty: assert property (@(posedge clk) disable iff (!rst)
        credit == '0 |-> !busy)
        else begin
            $error("busy high with zero credit");
            fail_cnt++;
        end

endmodule

bind vend_credit vend_credit_props props0 (.*);

// ==== dv/vend_checker.sv ====
module vend_checker (
    input logic                       clk,
    input logic                       rst,
    input logic [vend_pkg::KEY_W-1:0] keys,
    input logic                       coin_ack,
    input vend_pkg::panel_t           panel,
    input vend_pkg::credit_t          credit,
    input vend_pkg::stock_t           stock_shown,
    input logic                       coin_req,
    input logic                       test_end,
    input int                         test_num,
    output int                        errors
);
    timeunit 1ns;
    timeprecision 1ps;

    // reference state, panel side
    int              m_cursor;
    logic            m_sel_valid;
    int              m_sel_item;
    logic            m_admin;
    vend_pkg::msg_t  m_msg;
    int              m_msg_item;
    int              m_hold;
    // reference state, registers one cycle behind the panel
    int   m_stock [vend_pkg::NUM_ITEMS];
    int   m_cr;
    logic m_req;
    int   m_pay;
    // commands waiting for the next edge
    logic p_sell, p_restock, p_add, p_charge, p_refund;
    int   p_item, p_amt, p_price;
    int   refund_amt;
    int   handshakes;
    int   test_err_base = 0;

    initial errors = 0;

    function automatic int item_price(input int item);
        int prices [4] = '{10, 12, 15, 18};
        return prices[item];
    endfunction

    function automatic string test_name(input int t);
        string names [5] = '{"navigation", "coins and cap", "select and buy",
                             "refund handshake", "admin restock"};
        return names[t];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        logic [2:0] coins;
        logic       busy_now;
        int         val;
        int         price;
        if (!rst) begin
            m_cursor = 0;
            m_sel_valid = 0;
            m_sel_item = 0;
            m_admin = 0;
            m_msg = vend_pkg::MSG_NONE;
            m_msg_item = 0;
            m_hold = 0;
            m_stock = '{9, 1, 0, 4};
            m_cr = 0;
            m_req = 0;
            m_pay = 0;
            {p_sell, p_restock, p_add, p_charge, p_refund} = '0;
        end else begin
            busy_now = (m_pay != 0) || (p_refund && m_cr != 0);
            if (coin_req && coin_ack)
                handshakes++;
            // stock updates from the previous cycle's sale or restock
            if (p_sell && m_stock[p_item] > 0)
                m_stock[p_item]--;
            if (p_restock && m_stock[p_item] < 9)
                m_stock[p_item]++;
            // credit register and hopper payout
            case (m_pay)
                0: begin
                    if (p_refund && m_cr != 0) begin
                        refund_amt = m_cr;
                        handshakes = 0;
                        m_pay = coin_ack ? 2 : 1;
                        m_req = !coin_ack;
                    end
                    if (p_add)
                        m_cr += p_amt;
                    else if (p_charge)
                        m_cr -= p_price;
                end
                1: begin
                    if (coin_ack) begin
                        m_req = 0;
                        m_cr--;
                        m_pay = (m_cr == 0) ? 0 : 2;
                        if (m_cr == 0 && handshakes != refund_amt)
                            report_mismatch("refund handshakes", refund_amt, handshakes);
                    end
                end
                default: begin
                    if (!coin_ack) begin
                        m_req = 1;
                        m_pay = 1;
                    end
                end
            endcase
            {p_sell, p_restock, p_add, p_charge, p_refund} = '0;

            if (m_msg != vend_pkg::MSG_NONE) begin
                m_hold--;
                if (m_hold == 0) begin
                    m_msg = vend_pkg::MSG_NONE;
                    m_msg_item = 0;
                end
            end

            coins = {keys[vend_pkg::KEY_COIN1], keys[vend_pkg::KEY_COIN5],
                     keys[vend_pkg::KEY_COIN10]};
            if (keys[vend_pkg::KEY_UP]) begin
                if (m_cursor > 0)
                    m_cursor--;
            end else if (keys[vend_pkg::KEY_DOWN]) begin
                if (m_cursor < 3)
                    m_cursor++;
            end else if (keys[vend_pkg::KEY_SELECT]) begin
                if (m_sel_valid && m_sel_item == m_cursor) begin
                    m_sel_valid = 0;
                end else if (m_stock[m_cursor] != 0) begin
                    m_sel_valid = 1;
                    m_sel_item = m_cursor;
                end
            end else if (coins != 0 && !busy_now) begin
                val = coins[2] ? 1 : (coins[1] ? 5 : 10);
                if ((coins == 3'b100 || coins == 3'b010 || coins == 3'b001)
                    && m_cr + val <= 99) begin
                    p_add = 1;
                    p_amt = val;
                end
            end else if (keys[vend_pkg::KEY_BUY] && !busy_now) begin
                if (m_sel_valid) begin
                    price = item_price(m_sel_item);
                    m_msg_item = m_sel_item;
                    m_hold = vend_pkg::MSG_HOLD;
                    m_sel_valid = 0;
                    if (m_stock[m_sel_item] == 0) begin
                        m_msg = vend_pkg::MSG_SOLD_OUT;
                    end else if (m_cr < price) begin
                        m_msg = vend_pkg::MSG_SHORT;
                    end else begin
                        p_sell = 1;
                        p_item = m_sel_item;
                        p_charge = 1;
                        p_price = price;
                        m_msg = vend_pkg::MSG_THANKS;
                    end
                end
            end else if (keys[vend_pkg::KEY_REFUND] && !busy_now) begin
                p_refund = 1;
            end else if (keys[vend_pkg::KEY_RESTOCK]) begin
                if (m_admin) begin
                    p_restock = 1;
                    p_item = m_cursor;
                end
            end else if (keys[vend_pkg::KEY_ADMIN]) begin
                if (!m_admin) begin
                    m_msg = vend_pkg::MSG_ADMIN;
                    m_msg_item = m_cursor;
                    m_hold = vend_pkg::MSG_HOLD;
                end
                m_admin = !m_admin;
            end
        end
    end

    //////////////////////////////////////////////////
    // comparison, mid cycle where outputs are settled
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        vend_pkg::panel_t exp;
        if (rst) begin
            exp.cursor = vend_pkg::item_t'(m_cursor);
            exp.sel_valid = m_sel_valid;
            exp.sel_item = vend_pkg::item_t'(m_sel_item);
            exp.admin = m_admin;
            exp.msg = m_msg;
            exp.msg_item = vend_pkg::item_t'(m_msg_item);
            if (panel !== exp)
                report_mismatch("panel", exp, panel);
            if (credit !== vend_pkg::credit_t'(m_cr))
                report_mismatch("credit", m_cr, credit);
            if (stock_shown !== vend_pkg::stock_t'(m_stock[m_cursor]))
                report_mismatch("stock_shown", m_stock[m_cursor], stock_shown);
            if (coin_req !== m_req)
                report_mismatch("coin_req", m_req, coin_req);
        end
        if (test_end) begin
            $display("test %0d %s: %s, %0d errors", test_num, test_name(test_num),
                     (errors == test_err_base) ? "ok" : "failed", errors - test_err_base);
            test_err_base = errors;
        end
    end

endmodule

// ==== dv/vend_tb.sv ====
module vend_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 5;

    logic                       clk;
    logic                       rst;
    logic [vend_pkg::KEY_W-1:0] keys;
    logic                       coin_ack;
    vend_pkg::panel_t           panel;
    vend_pkg::credit_t          credit;
    vend_pkg::stock_t           stock_shown;
    logic                       coin_req;
    logic                       test_end;
    int                         test_num;
    int                         errors;

    int seed = 32'h4c5a_f76b;
    int hop_seed = 32'h4c5a_f76b;
    int test_len [NUM_TESTS] = '{40, 40, 60, 40, 40};
    logic [vend_pkg::KEY_W-1:0] key_q [$];
    int cycles = 0;
    int limit = 0;
    logic ack_armed;
    int   ack_delay;

    vend_top dut0 (.*);

    vend_checker chk0 (.*);

    always #20 clk = ~clk;

    function automatic logic [vend_pkg::KEY_W-1:0] key_bit(input int pos);
        return vend_pkg::KEY_W'(1) << pos;
    endfunction

    // each test leans toward its own keys
    function automatic logic [vend_pkg::KEY_W-1:0] pick_key(input int t);
        int r;
        r = $unsigned($random(seed)) % 10;
        case (t)
            0: return (r < 5) ? key_bit(vend_pkg::KEY_UP) : key_bit(vend_pkg::KEY_DOWN);
            1: begin
                if (r < 3) return key_bit(vend_pkg::KEY_COIN1);
                if (r < 6) return key_bit(vend_pkg::KEY_COIN5);
                if (r < 9) return key_bit(vend_pkg::KEY_COIN10);
                return vend_pkg::KEY_W'(3'b011);
            end
            2: begin
                if (r < 2) return key_bit(vend_pkg::KEY_UP);
                if (r < 4) return key_bit(vend_pkg::KEY_DOWN);
                if (r < 6) return key_bit(vend_pkg::KEY_SELECT);
                if (r < 8) return key_bit(vend_pkg::KEY_BUY);
                return key_bit(vend_pkg::KEY_COIN10);
            end
            3: begin
                if (r < 3) return key_bit(vend_pkg::KEY_COIN10);
                if (r < 4) return key_bit(vend_pkg::KEY_COIN5);
                if (r < 5) return key_bit(vend_pkg::KEY_BUY);
                if (r < 6) return key_bit(vend_pkg::KEY_SELECT);
                if (r < 8) return key_bit(vend_pkg::KEY_REFUND);
                return key_bit(vend_pkg::KEY_DOWN);
            end
            default: begin
                if (r < 3) return key_bit(vend_pkg::KEY_ADMIN);
                if (r < 7) return key_bit(vend_pkg::KEY_RESTOCK);
                if (r < 8) return key_bit(vend_pkg::KEY_UP);
                return key_bit(vend_pkg::KEY_DOWN);
            end
        endcase
    endfunction

    //////////////////////////////////////////////////
    // hopper model that follows req with ack after 1 to 4 cycles
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        int pick;
        if (!rst) begin
            coin_ack <= 1'b0;
            ack_armed <= 1'b0;
        end else if (!ack_armed && coin_req != coin_ack) begin
            pick = 1 + ($unsigned($random(hop_seed)) % 4);
            if (pick == 1) begin
                coin_ack <= coin_req;
            end else begin
                ack_armed <= 1'b1;
                ack_delay <= pick - 1;
            end
        end else if (ack_armed) begin
            if (ack_delay <= 1) begin
                coin_ack <= coin_req;
                ack_armed <= 1'b0;
            end else begin
                ack_delay <= ack_delay - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int total;
        int refunds;
        int idx;
        int total_errors;
        clk = 1'b0;
        rst = 1'b0;
        keys = '0;
        coin_ack = 1'b0;
        ack_armed = 1'b0;
        ack_delay = 0;
        test_end = 1'b0;
        test_num = 0;
        total = 0;
        refunds = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int p = 0; p < test_len[t]; p++) begin
                key_q.push_back(pick_key(t));
                if (key_q[$][vend_pkg::KEY_REFUND])
                    refunds++;
            end
            total += test_len[t];
        end
        limit = total * 4 + refunds * vend_pkg::CREDIT_MAX * 10 + 100;

        repeat (3) @(posedge clk);
        rst <= 1'b1;
        idx = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int p = 0; p < test_len[t]; p++) begin
                @(posedge clk);
                keys <= key_q[idx];
                idx++;
                @(posedge clk);
                keys <= '0;
                if (p == test_len[t] - 1) begin
                    test_num <= t;
                    test_end <= 1'b1;
                end
                @(posedge clk);
                test_end <= 1'b0;
                @(posedge clk);
            end
        end

        // let a running payout and the last message finish
        while (dut0.credit0.busy)
            @(posedge clk);
        repeat (vend_pkg::MSG_HOLD + 2) @(posedge clk);
        total_errors = errors + dut0.credit0.props0.fail_cnt;
        $display("tests run: %0d, errors: %0d", NUM_TESTS, total_errors);
        if (total_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== files.f ====
design/vend_pkg.sv
design/vend_sale_control.sv
design/vend_stock_ledger.sv
design/vend_credit.sv
design/vend_top.sv
dv/vend_credit_props.sv
dv/vend_checker.sv
dv/vend_tb.sv
